/* Makefile */
TOP := tb_pkt_check_array

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* include/pkt_check_defs.svh */
// widths and default lane count for the packet checker.
// lengths count whole 32-bit words; the header fields must fill exactly one beat.
`ifndef PKT_CHECK_DEFS_SVH
`define PKT_CHECK_DEFS_SVH

// beat width.
`define PC_DATA_W 32

// default number of lanes.
`define PC_NUM_PORTS 2

// sequence id, payload word count and packet counter widths.
`define PC_SEQ_W 8
`define PC_LEN_W 16
`define PC_CNT_W 16

`endif

/* logic/pkt_check_array.sv */
// per-lane packet checker array; lanes are independent, no back-pressure.
// result_valid follows the trailer beat by exactly two cycles.
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_check_array
    import pkt_check_pkg::*;
#(
    parameter int NUM_PORTS = `PC_NUM_PORTS
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [NUM_PORTS-1:0]            beat_valid,
    input  logic [NUM_PORTS-1:0]            beat_last,
    input  logic [NUM_PORTS*`PC_DATA_W-1:0] beat_data,
    output logic [NUM_PORTS-1:0]            result_valid,
    output logic [NUM_PORTS-1:0]            result_len_err,
    output logic [NUM_PORTS-1:0]            result_seq_err,
    output logic [NUM_PORTS-1:0]            result_sum_err,
    output logic [NUM_PORTS*`PC_SEQ_W-1:0]  result_seq_id,
    output logic [NUM_PORTS*`PC_CNT_W-1:0]  good_count,
    output logic [NUM_PORTS*`PC_CNT_W-1:0]  bad_count
);

    if (NUM_PORTS < 1) begin : g_bad_ports
        $error("pkt_check_array needs at least one lane");
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
        pkt_word_u            lane_word; // same beat, read two ways below.
        logic                 frame_done;
        logic                 len_err;
        logic                 seq_err;
        logic [`PC_SEQ_W-1:0] done_seq_id;
        logic                 sum_done;
        logic                 sum_err;

        assign lane_word = beat_data[i*`PC_DATA_W +: `PC_DATA_W];

        pkt_frame_tracker u_tracker (
            .clk         (clk),
            .arst_n      (arst_n),
            .beat_valid  (beat_valid[i]),
            .beat_last   (beat_last[i]),
            .beat_data   (lane_word),
            .frame_done  (frame_done),
            .len_err     (len_err),
            .seq_err     (seq_err),
            .done_seq_id (done_seq_id)
        );

        pkt_payload_sum u_sum (
            .clk        (clk),
            .arst_n     (arst_n),
            .beat_valid (beat_valid[i]),
            .beat_last  (beat_last[i]),
            .beat_data  (lane_word),
            .sum_done   (sum_done),
            .sum_err    (sum_err)
        );

        pkt_verdict u_verdict (
            .clk            (clk),
            .arst_n         (arst_n),
            .frame_done     (frame_done),
            .len_err        (len_err),
            .seq_err        (seq_err),
            .done_seq_id    (done_seq_id),
            .sum_done       (sum_done),
            .sum_err        (sum_err),
            .result_valid   (result_valid[i]),
            .result_len_err (result_len_err[i]),
            .result_seq_err (result_seq_err[i]),
            .result_sum_err (result_sum_err[i]),
            .result_seq_id  (result_seq_id[i*`PC_SEQ_W +: `PC_SEQ_W]),
            .good_count     (good_count[i*`PC_CNT_W +: `PC_CNT_W]),
            .bad_count      (bad_count[i*`PC_CNT_W +: `PC_CNT_W])
        );
    end

endmodule

/* logic/pkt_check_pkg.sv */
// header layout for the first beat of a packet, seq_id in the top byte.
// pkt_type is carried through but never checked.
`include "pkt_check_defs.svh"

package pkt_check_pkg;

    // header fields, msb first.
    typedef struct packed {
        logic [`PC_SEQ_W-1:0]                       seq_id;
        logic [`PC_DATA_W-`PC_SEQ_W-`PC_LEN_W-1:0]  pkt_type;
        logic [`PC_LEN_W-1:0]                       payload_words;
    } pkt_hdr_t;

    // one beat, read as header fields or as a plain word for the sum.
    typedef union packed {
        pkt_hdr_t               hdr;
        logic [`PC_DATA_W-1:0]  raw;
    } pkt_word_u;

endpackage

/* logic/pkt_frame_tracker.sv */
// one lane, no back-pressure; a packet of payload_words n is n+2 beats.
// frame_done is registered on the edge that takes the closing beat.
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_frame_tracker
    import pkt_check_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 beat_valid,
    input  logic                 beat_last,
    input  pkt_word_u            beat_data,
    output logic                 frame_done,
    output logic                 len_err,
    output logic                 seq_err,
    output logic [`PC_SEQ_W-1:0] done_seq_id
);

    localparam int BC_W = `PC_LEN_W + 1; // holds payload_words+2.

    logic                 expect_hdr;   // next beat is a header.
    logic [BC_W-1:0]      beat_cnt;
    logic [`PC_LEN_W-1:0] lat_len;
    logic [`PC_SEQ_W-1:0] lat_seq;
    logic [`PC_SEQ_W-1:0] exp_seq;
    logic                 seq_bad;      // header of the open packet had a bad id.

    logic [BC_W-1:0]      next_cnt;
    logic [BC_W-1:0]      limit;
    logic [`PC_LEN_W-1:0] cur_len;
    logic [`PC_SEQ_W-1:0] cur_seq;
    logic                 hdr_seq_bad;
    logic                 cur_seq_bad;
    logic                 close;

    // on a header beat the fields come straight from the bus.
    assign cur_len     = expect_hdr ? beat_data.hdr.payload_words : lat_len;
    assign cur_seq     = expect_hdr ? beat_data.hdr.seq_id : lat_seq;
    assign hdr_seq_bad = beat_data.hdr.seq_id != exp_seq;
    assign cur_seq_bad = expect_hdr ? hdr_seq_bad : seq_bad;

    assign next_cnt = expect_hdr ? BC_W'(1) : beat_cnt + 1'b1;
    assign limit    = {1'b0, cur_len} + BC_W'(2);

    // trailer, or forced close once the declared length is reached.
    assign close = beat_valid && (beat_last || next_cnt == limit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            expect_hdr <= 1'b1;
            beat_cnt   <= '0;
            exp_seq    <= '0;
            seq_bad    <= 1'b0;
            frame_done <= 1'b0;
            len_err    <= 1'b0;
            seq_err    <= 1'b0;
        end else begin
            frame_done <= close;
            len_err    <= close && (next_cnt != limit);
            seq_err    <= close && cur_seq_bad;
            if (beat_valid) begin
                beat_cnt   <= next_cnt;
                expect_hdr <= close;
                if (expect_hdr) begin
                    exp_seq <= beat_data.hdr.seq_id + 1'b1; // resync to received id.
                    seq_bad <= hdr_seq_bad;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid && expect_hdr) begin
            lat_len <= beat_data.hdr.payload_words;
            lat_seq <= beat_data.hdr.seq_id;
        end
        if (close)
            done_seq_id <= cur_seq;
    end

    // an open packet never runs past its declared length.
    a_cnt_in_limit: assert property (@(posedge clk) disable iff (!arst_n)
        !expect_hdr |-> beat_cnt < {1'b0, lat_len} + BC_W'(2));

endmodule

/* logic/pkt_payload_sum.sv */
// one lane; closes a packet on beat_last only, the sum wraps at 32 bits.
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_payload_sum
    import pkt_check_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      beat_valid,
    input  logic      beat_last,
    input  pkt_word_u beat_data,
    output logic      sum_done,
    output logic      sum_err
);

    logic [`PC_DATA_W-1:0] acc; // sum of header and payload so far.
    logic                  trailer;

    assign trailer = beat_valid && beat_last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc      <= '0;
            sum_done <= 1'b0;
            sum_err  <= 1'b0;
        end else begin
            sum_done <= trailer;
            sum_err  <= trailer && (acc != beat_data.raw);
            if (trailer)
                acc <= '0;                    // ready for the next header.
            else if (beat_valid)
                acc <= acc + beat_data.raw;
        end
    end

endmodule

/* logic/pkt_verdict.sv */
// one lane; one result per frame_done, two cycles after the closing beat.
// a frame closed without its own sum check is reported with result_sum_err.
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module pkt_verdict (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 frame_done,
    input  logic                 len_err,
    input  logic                 seq_err,
    input  logic [`PC_SEQ_W-1:0] done_seq_id,
    input  logic                 sum_done,
    input  logic                 sum_err,
    output logic                 result_valid,
    output logic                 result_len_err,
    output logic                 result_seq_err,
    output logic                 result_sum_err,
    output logic [`PC_SEQ_W-1:0] result_seq_id,
    output logic [`PC_CNT_W-1:0] good_count,
    output logic [`PC_CNT_W-1:0] bad_count
);

    logic sum_orphan;  // a frame was force-closed, its trailer is still to come.
    logic pkt_sum_err;
    logic pkt_bad;

    // no coincident sum check means the sum is unverified.
    assign pkt_sum_err = sum_done ? sum_err : 1'b1;
    assign pkt_bad     = len_err | seq_err | pkt_sum_err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            good_count   <= '0;
            bad_count    <= '0;
            sum_orphan   <= 1'b0;
        end else begin
            result_valid <= frame_done;
            if (frame_done) begin
                if (pkt_bad)
                    bad_count <= bad_count + 1'b1;
                else
                    good_count <= good_count + 1'b1;
            end
            if (sum_done)
                sum_orphan <= 1'b0;
            else if (frame_done)
                sum_orphan <= 1'b1;
        end
    end

    // result fields, valid with result_valid.
    always_ff @(posedge clk) begin
        if (frame_done) begin
            result_len_err <= len_err;
            result_seq_err <= seq_err;
            result_sum_err <= pkt_sum_err;
            result_seq_id  <= done_seq_id;
        end
    end

    // a lone sum_done belongs to a packet the tracker already closed short.
    a_sum_in_step: assert property (@(posedge clk) disable iff (!arst_n)
        (sum_done && !frame_done) |-> sum_orphan);

endmodule

/* tests/pkt_check_vectors.txt */
# T name gaps | V lane seq_id len_err seq_err sum_err name | K good0 bad0 good1 bad1
# C valid0 last0 data0 valid1 last1 data1 is one clock of beats; R pulses reset; all hex
T good_ids 1
V 0 00 0 0 0 good_ids
V 0 01 0 0 0 good_ids
V 0 02 0 0 0 good_ids
C 1 0 00A50001 0 0 00000000
C 1 0 11111111 0 0 00000000
C 1 1 11B61112 0 0 00000000
C 1 0 01A50000 0 0 00000000
C 1 1 01A50000 0 0 00000000
C 1 0 02A50000 0 0 00000000
C 1 1 02A50000 0 0 00000000
K 3 0 0 0
T bad_sum 1
V 0 03 0 0 1 bad_sum
C 1 0 03A50000 0 0 00000000
C 1 1 03A50001 0 0 00000000
K 3 1 0 0
T seq_skip 1
V 0 06 0 1 0 seq_skip
V 0 07 0 0 0 seq_skip
C 1 0 06A50000 0 0 00000000
C 1 1 06A50000 0 0 00000000
C 1 0 07A50000 0 0 00000000
C 1 1 07A50000 0 0 00000000
K 4 2 0 0
T length 1
V 0 08 1 0 0 length
V 0 09 0 0 1 length
V 0 0A 1 0 0 length
C 1 0 08A50002 0 0 00000000
C 1 0 00000010 0 0 00000000
C 1 1 08A50012 0 0 00000000
C 1 0 09A50000 0 0 00000000
C 1 0 01000000 0 0 00000000
C 1 1 0AA50000 0 0 00000000
K 4 5 0 0
T interleave 0
V 0 0B 0 0 0 interleave
V 0 0C 0 0 0 interleave
V 1 00 0 0 0 interleave
V 1 01 0 0 0 interleave
V 1 02 0 0 1 interleave
C 1 0 0BA50001 1 0 00B70000
C 1 0 00000005 1 1 00B70000
C 1 1 0BA50006 1 0 01B70001
C 1 0 0CA50000 1 0 FFFFFFFF
C 1 1 0CA50000 1 1 01B70000
C 0 0 00000000 1 0 02B70000
C 0 0 00000000 1 1 02B70001
K 6 5 2 1
T reset_mid 1
C 1 0 0DA50002 0 0 00000000
C 1 0 00000001 0 0 00000000
R
K 0 0 0 0
V 0 00 0 0 0 reset_mid
C 1 0 00A50000 0 0 00000000
C 1 1 00A50000 0 0 00000000
K 1 0 0 0

/* tests/tb_pkt_check_array.sv */
// runs from the project root and reads tests/pkt_check_vectors.txt; two lanes only.
// results are sampled on the falling edge, two cycles after each trailer beat.
`timescale 1ns/1ps
`include "pkt_check_defs.svh"

module tb_pkt_check_array;

    localparam int NP        = 2;
    localparam int PERIOD    = 8;
    localparam int DRAIN_MAX = 4;   // result latency is 2 cycles.

    logic                     clk;
    logic                     arst_n;
    logic [NP-1:0]            beat_valid;
    logic [NP-1:0]            beat_last;
    logic [NP*`PC_DATA_W-1:0] beat_data;
    logic [NP-1:0]            result_valid;
    logic [NP-1:0]            result_len_err;
    logic [NP-1:0]            result_seq_err;
    logic [NP-1:0]            result_sum_err;
    logic [NP*`PC_SEQ_W-1:0]  result_seq_id;
    logic [NP*`PC_CNT_W-1:0]  good_count;
    logic [NP*`PC_CNT_W-1:0]  bad_count;

    string       lines[$];
    logic [10:0] exp_q[NP][$];      // {seq_id, len_err, seq_err, sum_err}.
    string       name_q[NP][$];
    string       cur_name = "none";
    int          seed = 32'hac4b_fdbc;
    int          err_count = 0;
    int          test_errs = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          budget_cycles = 0;
    bit          gaps_on = 1'b0;
    bit          test_open = 1'b0;

    pkt_check_array #(.NUM_PORTS(NP)) u_dut (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic check_value(input string sig, input int lane, input string tname,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch at %0t ns: %s lane %0d expected %h, got %h (test %s)",
                     $time, sig, lane, exp_v, act_v, tname);
            err_count++;
        end
    endtask

    task automatic bad_record(input string line);
        $display("unreadable record in the vector file: %s", line);
        err_count++;
    endtask

    task automatic collect_result(input int lane);
        logic [10:0] e;
        string       tname;
        if (exp_q[lane].size() == 0) begin
            $display("lane %0d gave a result for seq id %h at %0t ns with no verdict expected",
                     lane, result_seq_id[lane*`PC_SEQ_W +: `PC_SEQ_W], $time);
            err_count++;
        end else begin
            e     = exp_q[lane].pop_front();
            tname = name_q[lane].pop_front();
            check_value("result_seq_id", lane, tname, 32'(e[10:3]),
                        32'(result_seq_id[lane*`PC_SEQ_W +: `PC_SEQ_W]));
            check_value("result_len_err", lane, tname, 32'(e[2]), 32'(result_len_err[lane]));
            check_value("result_seq_err", lane, tname, 32'(e[1]), 32'(result_seq_err[lane]));
            check_value("result_sum_err", lane, tname, 32'(e[0]), 32'(result_sum_err[lane]));
        end
    endtask

    // outputs settle after the rising edge, so they are read on the falling one.
    always @(negedge clk) begin
        if (arst_n) begin
            for (int i = 0; i < NP; i++) begin
                if (result_valid[i])
                    collect_result(i);
            end
        end
    end

    task automatic idle_cycle();
        @(negedge clk);
        beat_valid = '0;
        beat_last  = '0;
    endtask

    task automatic drive_cycle(input string line);
        logic [31:0] v0, l0, d0, v1, l1, d1;
        int          gap;
        if ($sscanf(line, "C %h %h %h %h %h %h", v0, l0, d0, v1, l1, d1) != 6) begin
            bad_record(line);
        end else begin
            @(negedge clk);
            beat_valid = {v1[0], v0[0]};
            beat_last  = {l1[0], l0[0]};
            beat_data  = {d1, d0};
            if (gaps_on && (l0[0] || l1[0])) begin
                gap = $random(seed) & 3;     // 0 to 3 idle cycles.
                repeat (gap) idle_cycle();
            end
        end
    endtask

    task automatic expect_verdict(input string line);
        int          lane;
        logic [31:0] seq, le, se, su;
        string       tname;
        if ($sscanf(line, "V %h %h %h %h %h %s", lane, seq, le, se, su, tname) != 6
                || lane < 0 || lane >= NP) begin
            bad_record(line);
        end else begin
            exp_q[lane].push_back({seq[7:0], le[0], se[0], su[0]});
            name_q[lane].push_back(tname);
        end
    endtask

    task automatic drain_results();
        int waited;
        idle_cycle();
        waited = 0;
        while ((exp_q[0].size() + exp_q[1].size()) != 0 && waited < DRAIN_MAX) begin
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < NP; i++) begin
            if (exp_q[i].size() != 0) begin
                $display("lane %0d never produced %0d expected results in test %s",
                         i, exp_q[i].size(), cur_name);
                err_count++;
                exp_q[i].delete();
                name_q[i].delete();
            end
        end
    endtask

    task automatic check_counts(input string line);
        logic [31:0] g0, b0, g1, b1;
        if ($sscanf(line, "K %h %h %h %h", g0, b0, g1, b1) != 4) begin
            bad_record(line);
        end else begin
            drain_results();
            check_value("good_count", 0, cur_name, g0, 32'(good_count[0 +: `PC_CNT_W]));
            check_value("bad_count", 0, cur_name, b0, 32'(bad_count[0 +: `PC_CNT_W]));
            check_value("good_count", 1, cur_name, g1, 32'(good_count[`PC_CNT_W +: `PC_CNT_W]));
            check_value("bad_count", 1, cur_name, b1, 32'(bad_count[`PC_CNT_W +: `PC_CNT_W]));
        end
    endtask

    task automatic finish_test();
        drain_results();
        if (err_count == test_errs) begin
            $display("test %s passed", cur_name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", cur_name, err_count - test_errs);
            tests_failed++;
        end
        test_open = 1'b0;
    endtask

    task automatic start_test(input string line);
        string       tname;
        logic [31:0] g;
        if ($sscanf(line, "T %s %h", tname, g) != 2) begin
            bad_record(line);
        end else begin
            if (test_open)
                finish_test();
            cur_name  = tname;
            gaps_on   = g[0];
            test_errs = err_count;
            test_open = 1'b1;
        end
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        beat_valid = '0;
        beat_last  = '0;
        arst_n     = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic run_record(input string line);
        case (line.getc(0))
            "T": start_test(line);
            "V": expect_verdict(line);
            "C": drive_cycle(line);
            "K": check_counts(line);
            "R": pulse_reset();
            default: bad_record(line);
        endcase
    endtask

    // loads every record and sizes the watchdog from them.
    function automatic bit read_vectors();
        int    fd;
        int    cycles;
        string line;
        fd = $fopen("tests/pkt_check_vectors.txt", "r");
        if (fd == 0)
            return 1'b0;
        cycles = 20;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
                case (line.getc(0))
                    "C":      cycles += 4;   // beat plus its largest gap.
                    "K", "T": cycles += DRAIN_MAX + 2;
                    "R":      cycles += 3;
                    default:  cycles += 0;
                endcase
            end
        end
        $fclose(fd);
        budget_cycles = cycles;
        return 1'b1;
    endfunction

    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete", budget_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        beat_valid = '0;
        beat_last  = '0;
        beat_data  = '0;
        arst_n     = 1'b0;
        if (!read_vectors()) begin
            $display("cannot open tests/pkt_check_vectors.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (2) @(negedge clk);
            arst_n = 1'b1;
            foreach (lines[k])
                run_record(lines[k]);
            if (test_open)
                finish_test();
            $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
            if (tests_failed == 0 && err_count == 0)
                $display("TEST OK");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+include
logic/pkt_check_pkg.sv
logic/pkt_frame_tracker.sv
logic/pkt_payload_sum.sv
logic/pkt_verdict.sv
logic/pkt_check_array.sv
tests/tb_pkt_check_array.sv
